// ==== files.f ====
rtl/sat_pkg.sv
rtl/flip_pkg.sv
rtl/literal_issue.sv
rtl/occurrence_table.sv
rtl/variable_table.sv
rtl/break_evaluator.sv
rtl/flip_selector.sv
rtl/walksat_datapath.sv
tests/tb_clock.sv
tests/walksat_datapath_tb.sv

// ==== tests/walksat_datapath_tb.sv ====
////////////////////////////////////////
// walksat datapath testbench
// random assignment and occurrence rows,
// greedy flip checked against a model
////////////////////////////////////////
`default_nettype none

module walksat_datapath_tb import sat_pkg::*, flip_pkg::*; ();

    localparam int DRIVE_DELAY = 1;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_RANDOM_CLAUSES = 40;
    localparam int NUM_EMPTY_CLAUSES = 8;
    // top variables get no occurrences at all
    localparam int EMPTY_BITS = 3;
    localparam int EMPTY_BASE = NUM_VARIABLES - (1 << EMPTY_BITS);
    localparam int DONE_WAIT_LIMIT = 4 * PIPE_LATENCY;
    localparam int LOAD_CYCLES = 2 * NUM_VARIABLES * MC + 4 * NUM_VARIABLES;
    localparam int CLAUSE_CYCLES =
        (NUM_RANDOM_CLAUSES + NUM_EMPTY_CLAUSES) * (PIPE_LATENCY + 3);
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + LOAD_CYCLES + CLAUSE_CYCLES + 200;

    logic clk, rst_i, start_i, occ_wr_en_i, var_wr_en_i, var_wr_data_i;
    clause_t      clause_i;
    lit_t         occ_wr_lit_i;
    occ_slot_t    occ_wr_slot_i;
    occ_entry_t   occ_wr_entry_i;
    var_addr_t    var_wr_addr_i, var_rd_addr_i, flip_var_o;
    logic         busy_o, done_o, var_rd_data_o;
    break_count_t break_count_o;

    // model state
    logic [NUM_VARIABLES-1:0] model_assign;
    occ_entry_t  model_occ [2*NUM_VARIABLES][MC];
    logic [15:0] lfsr_q;
    int check_count = 0;
    int error_count = 0;
    int cycle_count = 0;

    tb_clock #(.PERIOD(4)) u_clock (.clk_o(clk));

    walksat_datapath walksat_datapath_i (
        .clk(clk), .rst_i(rst_i), .clause_i(clause_i), .start_i(start_i),
        .occ_wr_en_i(occ_wr_en_i), .occ_wr_lit_i(occ_wr_lit_i),
        .occ_wr_slot_i(occ_wr_slot_i), .occ_wr_entry_i(occ_wr_entry_i),
        .var_wr_en_i(var_wr_en_i), .var_wr_addr_i(var_wr_addr_i),
        .var_wr_data_i(var_wr_data_i), .var_rd_addr_i(var_rd_addr_i),
        .busy_o(busy_o), .done_o(done_o), .flip_var_o(flip_var_o),
        .break_count_o(break_count_o), .var_rd_data_o(var_rd_data_o)
    );

    // taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    task automatic random_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val = {val[30:0], lfsr_q[0]};
        end
    endtask

    task automatic expect_equal(input logic [31:0] got, input logic [31:0] expected,
                                input string what);
        check_count++;
        assert (got === expected) else begin
            error_count++;
            $display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    // row number of a literal with the negation bit on top
    function automatic int lit_row(input lit_t lit);
        return lit.neg ? NUM_VARIABLES + int'(lit.addr) : int'(lit.addr);
    endfunction

    // clauses holding the negated literal whose other literals are all false
    function automatic int model_break_count(input lit_t lit);
        lit_t       neg_lit;
        occ_entry_t ent;
        logic       breaks;
        int         cnt;
        neg_lit = lit;
        neg_lit.neg = ~lit.neg;
        cnt = 0;
        for (int e = 0; e < MC; e++) begin
            ent = model_occ[lit_row(neg_lit)][e];
            breaks = ent.valid;
            for (int j = 0; j < OTHER_LITS; j++) begin
                // a literal is true when the value differs from its negation bit
                if (model_assign[ent.lits[j].addr] != ent.lits[j].neg) begin
                    breaks = 1'b0;
                end
            end
            cnt += int'(breaks);
        end
        return cnt;
    endfunction

    task automatic load_variables();
        logic [31:0] r;
        for (int v = 0; v < NUM_VARIABLES; v++) begin
            random_bits(1, r);
            var_wr_en_i = 1'b1;
            var_wr_addr_i = var_addr_t'(v);
            var_wr_data_i = r[0];
            model_assign[v] = r[0];
            @(posedge clk);
            #DRIVE_DELAY;
        end
        var_wr_en_i = 1'b0;
    endtask

    // every slot of every row gets written
    task automatic load_occurrences();
        logic [31:0] r;
        occ_entry_t  ent;
        lit_t        row_lit;
        for (int row = 0; row < 2 * NUM_VARIABLES; row++) begin
            row_lit.neg = row >= NUM_VARIABLES;
            row_lit.addr = var_addr_t'(row % NUM_VARIABLES);
            for (int s = 0; s < MC; s++) begin
                for (int j = 0; j < OTHER_LITS; j++) begin
                    random_bits(LIT_W, r);
                    ent.lits[j] = lit_t'(r[LIT_W-1:0]);
                end
                // roughly three slots in four hold a clause
                random_bits(2, r);
                ent.valid = (r[1:0] != 2'b00) && (int'(row_lit.addr) < EMPTY_BASE);
                model_occ[lit_row(row_lit)][s] = ent;
                occ_wr_en_i = 1'b1;
                occ_wr_lit_i = row_lit;
                occ_wr_slot_i = occ_slot_t'(s);
                occ_wr_entry_i = ent;
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        occ_wr_en_i = 1'b0;
    endtask

    // whole assignment through the read-back port while idle
    task automatic check_readback(input string phase);
        for (int v = 0; v < NUM_VARIABLES; v++) begin
            var_rd_addr_i = var_addr_t'(v);
            @(negedge clk);
            expect_equal(var_rd_data_o, model_assign[v],
                         $sformatf("%s readback of variable %0d", phase, v));
            expect_equal(busy_o, 1'b0, {phase, " busy_o"});
            expect_equal(done_o, 1'b0, {phase, " done_o"});
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic make_clause(input bit empty, output clause_t cl);
        logic [31:0] r;
        for (int i = 0; i < NSAT; i++) begin
            random_bits(1, r);
            cl[i].neg = r[0];
            random_bits(empty ? EMPTY_BITS : VAR_W, r);
            cl[i].addr = empty ? var_addr_t'(EMPTY_BASE + int'(r[EMPTY_BITS-1:0]))
                               : r[VAR_W-1:0];
        end
    endtask

    task automatic run_clause(input clause_t cl, input bit empty);
        int        counts [NSAT];
        int        best;
        int        sel;
        int        n;
        bit        seen;
        var_addr_t exp_var;
        // model on the assignment before the flip
        for (int i = 0; i < NSAT; i++) begin
            counts[i] = model_break_count(cl[i]);
        end
        best = counts[0];
        sel = 0;
        for (int i = 1; i < NSAT; i++) begin
            // ties stay with the lower index
            if (counts[i] < best) begin
                best = counts[i];
                sel = i;
            end
        end
        exp_var = cl[sel].addr;
        clause_i = cl;
        start_i = 1'b1;
        // watch the chosen variable through the whole run
        var_rd_addr_i = exp_var;
        n = 0;
        seen = 1'b0;
        while (!seen && n < DONE_WAIT_LIMIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            start_i = 1'b0;
            n++;
            @(negedge clk);
            expect_equal(busy_o, 1'b1, "busy_o while clause in flight");
            seen = (done_o === 1'b1);
        end
        check_count++;
        assert (seen) else begin
            error_count++;
            $display("done_o never rose within %0d cycles of start_i", DONE_WAIT_LIMIT);
        end
        expect_equal(n, PIPE_LATENCY, "cycles from start_i to done_o");
        expect_equal(break_count_o, best, "break_count_o");
        expect_equal(flip_var_o, exp_var, "flip_var_o");
        if (empty) begin
            expect_equal(break_count_o, 0, "break_count_o without occurrences");
            expect_equal(flip_var_o, cl[0].addr, "flip_var_o without occurrences");
        end
        model_assign[exp_var] = ~model_assign[exp_var];
        // flip is written on the edge that raises done_o
        expect_equal(var_rd_data_o, model_assign[exp_var],
                     "flipped variable readback while done_o");
        @(posedge clk);
        #DRIVE_DELAY;
        @(negedge clk);
        expect_equal(done_o, 1'b0, "done_o one cycle after done");
        expect_equal(busy_o, 1'b0, "busy_o one cycle after done");
        expect_equal(var_rd_data_o, model_assign[exp_var], "flipped variable readback");
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // cycle limit covers load, readbacks and every clause with margin
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without reaching the end", cycle_count);
            $display("checks: %0d, errors: %0d", check_count, error_count + 1);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        clause_t cl;
        lfsr_q = 16'd21070;
        rst_i = 1'b1;
        start_i = 1'b0;
        clause_i = '0;
        occ_wr_en_i = 1'b0;
        occ_wr_lit_i = '0;
        occ_wr_slot_i = '0;
        occ_wr_entry_i = '0;
        var_wr_en_i = 1'b0;
        var_wr_addr_i = '0;
        var_wr_data_i = 1'b0;
        var_rd_addr_i = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_i = 1'b0;
        // reset clears the whole assignment
        model_assign = '0;
        check_readback("after reset");
        load_variables();
        load_occurrences();
        check_readback("after load");
        for (int c = 0; c < NUM_RANDOM_CLAUSES; c++) begin
            make_clause(1'b0, cl);
            run_clause(cl, 1'b0);
        end
        for (int c = 0; c < NUM_EMPTY_CLAUSES; c++) begin
            make_clause(1'b1, cl);
            run_clause(cl, 1'b1);
        end
        check_readback("after flips");
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
////////////////////////////////////////
// testbench clock source
// free-running clock, low at time zero
////////////////////////////////////////
`default_nettype none

module tb_clock #(parameter int PERIOD = 4) (
    output logic clk_o
);

    initial clk_o = 1'b0;
    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== rtl/walksat_datapath.sv ====
////////////////////////////////////////
// walksat break/flip datapath top
// issue, occurrence lookup, break count,
// greedy select and flip
////////////////////////////////////////
`default_nettype none

module walksat_datapath import sat_pkg::*, flip_pkg::*; (
    input  wire             clk,
    input  wire             rst_i,

    input  wire clause_t    clause_i,
    input  wire             start_i,

    input  wire             occ_wr_en_i,
    input  wire lit_t       occ_wr_lit_i,
    input  wire occ_slot_t  occ_wr_slot_i,
    input  wire occ_entry_t occ_wr_entry_i,

    input  wire             var_wr_en_i,
    input  wire var_addr_t  var_wr_addr_i,
    input  wire             var_wr_data_i,
    input  wire var_addr_t  var_rd_addr_i,

    output logic            busy_o,
    output logic            done_o,
    output var_addr_t       flip_var_o,
    output break_count_t    break_count_o,
    output logic            var_rd_data_o
);

    // issue -> occurrence table
    logic         iss_valid;
    lit_index_t   iss_index;
    lit_t         iss_lit;

    // occurrence table -> evaluator
    logic         occ_valid;
    lit_index_t   occ_index;
    var_addr_t    occ_var;
    occ_row_t     occ_row;

    // evaluator <-> variable table
    var_addr_t [READ_PORTS-1:0] vt_addr;
    logic [READ_PORTS-1:0]      vt_data;

    // evaluator -> selector
    logic         ev_valid;
    lit_index_t   ev_index;
    var_addr_t    ev_var;
    break_count_t ev_count;

    // selector -> variable table
    logic         flip_en;
    var_addr_t    flip_addr;

    literal_issue u_issue (
        .clk(clk), .rst_i(rst_i), .start_i(start_i), .clause_i(clause_i),
        .iss_valid_o(iss_valid), .iss_index_o(iss_index), .iss_lit_o(iss_lit),
        .busy_o(busy_o)
    );

    occurrence_table u_occ (
        .clk(clk),
        .occ_wr_en_i(occ_wr_en_i), .occ_wr_lit_i(occ_wr_lit_i),
        .occ_wr_slot_i(occ_wr_slot_i), .occ_wr_entry_i(occ_wr_entry_i),
        .iss_valid_i(iss_valid), .iss_index_i(iss_index), .iss_lit_i(iss_lit),
        .occ_valid_o(occ_valid), .occ_index_o(occ_index),
        .occ_var_o(occ_var), .occ_row_o(occ_row)
    );

    break_evaluator u_eval (
        .clk(clk), .rst_i(rst_i),
        .occ_valid_i(occ_valid), .occ_index_i(occ_index),
        .occ_var_i(occ_var), .occ_row_i(occ_row),
        .vt_addr_o(vt_addr), .vt_data_i(vt_data),
        .ev_valid_o(ev_valid), .ev_index_o(ev_index),
        .ev_var_o(ev_var), .ev_count_o(ev_count)
    );

    variable_table u_vars (
        .clk(clk), .rst_i(rst_i),
        .var_wr_en_i(var_wr_en_i), .var_wr_addr_i(var_wr_addr_i),
        .var_wr_data_i(var_wr_data_i),
        .flip_en_i(flip_en), .flip_addr_i(flip_addr),
        .rd_addr_i(vt_addr), .rd_data_o(vt_data),
        .ext_rd_addr_i(var_rd_addr_i), .ext_rd_data_o(var_rd_data_o)
    );

    flip_selector u_select (
        .clk(clk), .rst_i(rst_i),
        .ev_valid_i(ev_valid), .ev_index_i(ev_index),
        .ev_var_i(ev_var), .ev_count_i(ev_count),
        .flip_en_o(flip_en), .flip_addr_o(flip_addr), .done_o(done_o),
        .flip_var_o(flip_var_o), .break_count_o(break_count_o)
    );

endmodule

`default_nettype wire

// ==== rtl/flip_selector.sv ====
////////////////////////////////////////
// flip selector
// lowest break count wins, ties go to the
// lower literal; pulses flip and done
////////////////////////////////////////
`default_nettype none

module flip_selector import sat_pkg::*, flip_pkg::*; (
    input  wire                clk,
    input  wire                rst_i,

    input  wire                ev_valid_i,
    input  wire lit_index_t    ev_index_i,
    input  wire var_addr_t     ev_var_i,
    input  wire break_count_t  ev_count_i,

    output logic               flip_en_o,
    output var_addr_t          flip_addr_o,
    output logic               done_o,
    output var_addr_t          flip_var_o,
    output break_count_t       break_count_o
);

    // running best over the clause so far
    break_count_t min_q;
    var_addr_t    min_var_q;

    logic         take_new;
    logic         last;
    break_count_t best_count;
    var_addr_t    best_var;
    logic         done_q;
    var_addr_t    sel_var_q;

    // strict compare keeps the earlier literal on a tie
    assign take_new = (ev_index_i == '0) || (ev_count_i < min_q);
    assign last     = ev_index_i == lit_index_t'(NSAT - 1);

    always_comb begin
        best_count = take_new ? ev_count_i : min_q;
        best_var   = take_new ? ev_var_i : min_var_q;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= ev_valid_i && last;
        end
    end

    always_ff @(posedge clk) begin
        if (ev_valid_i) begin
            min_q     <= best_count;
            min_var_q <= best_var;
        end
        // result held until the next clause finishes
        if (ev_valid_i && last) begin
            sel_var_q     <= best_var;
            break_count_o <= best_count;
        end
    end

    // flip lands in the table on the same edge that raises done
    assign flip_en_o   = ev_valid_i && last;
    assign flip_addr_o = best_var;
    assign done_o      = done_q;
    assign flip_var_o  = sel_var_q;

endmodule

`default_nettype wire

// ==== rtl/break_evaluator.sv ====
////////////////////////////////////////
// break evaluator
// counts occurrences that a flip would leave
// with no true literal
////////////////////////////////////////
`default_nettype none

module break_evaluator import sat_pkg::*, flip_pkg::*; (
    input  wire                              clk,
    input  wire                              rst_i,

    input  wire                              occ_valid_i,
    input  wire lit_index_t                  occ_index_i,
    input  wire var_addr_t                   occ_var_i,
    input  wire occ_row_t                    occ_row_i,

    // variable table lookup, answered in the same cycle
    output var_addr_t [READ_PORTS-1:0]       vt_addr_o,
    input  wire logic [READ_PORTS-1:0]       vt_data_i,

    output logic                             ev_valid_o,
    output lit_index_t                       ev_index_o,
    output var_addr_t                        ev_var_o,
    output break_count_t                     ev_count_o
);

    // slots whose clause hangs only on the flipped literal
    logic [MC-1:0] brk;
    break_count_t  count;

    // port e*OTHER_LITS+j serves literal j of slot e
    always_comb begin
        for (int e = 0; e < MC; e++) begin
            for (int j = 0; j < OTHER_LITS; j++) begin
                vt_addr_o[e*OTHER_LITS + j] = occ_row_i[e].lits[j].addr;
            end
        end
    end

    always_comb begin
        count = '0;
        for (int e = 0; e < MC; e++) begin
            brk[e] = occ_row_i[e].valid;
            for (int j = 0; j < OTHER_LITS; j++) begin
                // any true literal keeps the clause satisfied
                if (vt_data_i[e*OTHER_LITS + j] != occ_row_i[e].lits[j].neg) begin
                    brk[e] = 1'b0;
                end
            end
            count = count + break_count_t'(brk[e]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ev_valid_o <= 1'b0;
        end else begin
            ev_valid_o <= occ_valid_i;
        end
    end

    // count and its tag
    always_ff @(posedge clk) begin
        if (occ_valid_i) begin
            ev_index_o <= occ_index_i;
            ev_var_o   <= occ_var_i;
            ev_count_o <= count;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/variable_table.sv ====
////////////////////////////////////////
// variable table
// assignment bits, wide combinational reads,
// loader write and single-bit flip
////////////////////////////////////////
`default_nettype none

module variable_table import sat_pkg::*, flip_pkg::*; (
    input  wire                           clk,
    input  wire                           rst_i,

    // loader
    input  wire                           var_wr_en_i,
    input  wire var_addr_t                var_wr_addr_i,
    input  wire                           var_wr_data_i,

    // flip from the selector
    input  wire                           flip_en_i,
    input  wire var_addr_t                flip_addr_i,

    // evaluator ports
    input  wire var_addr_t [READ_PORTS-1:0] rd_addr_i,
    output logic [READ_PORTS-1:0]         rd_data_o,

    // read-back of the solver assignment
    input  wire var_addr_t                ext_rd_addr_i,
    output logic                          ext_rd_data_o
);

    logic [NUM_VARIABLES-1:0] assign_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            assign_q <= '0;
        end else if (var_wr_en_i) begin
            assign_q[var_wr_addr_i] <= var_wr_data_i;
        end else if (flip_en_i) begin
            // greedy move inverts the chosen variable
            assign_q[flip_addr_i] <= ~assign_q[flip_addr_i];
        end
    end

    // all evaluator lookups in parallel
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            rd_data_o[p] = assign_q[rd_addr_i[p]];
        end
    end

    assign ext_rd_data_o = assign_q[ext_rd_addr_i];

    // loading is only legal while the pipeline is idle
    no_load_during_flip: assert property (
        @(posedge clk) disable iff (rst_i) !(var_wr_en_i && flip_en_i)
    );

endmodule

`default_nettype wire

// ==== rtl/occurrence_table.sv ====
////////////////////////////////////////
// occurrence table
// one row per literal listing the clauses
// it appears in, registered read
////////////////////////////////////////
`default_nettype none

module occurrence_table import sat_pkg::*, flip_pkg::*; (
    input  wire             clk,

    // loader side, one slot per write
    input  wire             occ_wr_en_i,
    input  wire lit_t       occ_wr_lit_i,
    input  wire occ_slot_t  occ_wr_slot_i,
    input  wire occ_entry_t occ_wr_entry_i,

    // lookup from the issue stage
    input  wire             iss_valid_i,
    input  wire lit_index_t iss_index_i,
    input  wire lit_t       iss_lit_i,

    output logic            occ_valid_o,
    output lit_index_t      occ_index_o,
    output var_addr_t       occ_var_o,
    output occ_row_t        occ_row_o
);

    // both polarities of every variable
    occ_row_t occ_mem [2*NUM_VARIABLES];

    // slot write keeps the other entries of the row
    always_ff @(posedge clk) begin
        if (occ_wr_en_i) begin
            occ_mem[occ_wr_lit_i][occ_wr_slot_i] <= occ_wr_entry_i;
        end
    end

    // registered row read
    always_ff @(posedge clk) begin
        occ_row_o <= occ_mem[iss_lit_i];
    end

    // valid and tag line up with the row
    always_ff @(posedge clk) begin
        occ_valid_o <= iss_valid_i;
        occ_index_o <= iss_index_i;
        // flip only needs the plain address
        occ_var_o   <= iss_lit_i.addr;
    end

endmodule

`default_nettype wire

// ==== rtl/literal_issue.sv ====
////////////////////////////////////////
// literal issue stage
// latches a clause on start and feeds its
// negated literals out one per cycle
////////////////////////////////////////
`default_nettype none

module literal_issue import sat_pkg::*, flip_pkg::*; (
    input  wire          clk,
    input  wire          rst_i,
    input  wire          start_i,
    input  wire clause_t clause_i,
    output logic         iss_valid_o,
    output lit_index_t   iss_index_o,
    output lit_t         iss_lit_o,
    output logic         busy_o
);

    clause_t    clause_q;
    pipe_step_t step_q;
    logic       issue_now;
    lit_t       next_lit;

    // first literal comes straight from the input, the rest from the copy
    always_comb begin
        if (start_i) begin
            next_lit = clause_i[0];
        end else begin
            next_lit = clause_q[lit_index_t'(step_q)];
        end
        // the occurrence lookup wants the opposite polarity
        next_lit.neg = ~next_lit.neg;
    end

    // steps 1 .. NSAT-1 still have a literal to send
    assign issue_now = start_i || (busy_o && (step_q < pipe_step_t'(NSAT)));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_o      <= 1'b0;
            step_q      <= '0;
            iss_valid_o <= 1'b0;
        end else begin
            iss_valid_o <= issue_now;
            if (start_i) begin
                busy_o <= 1'b1;
                step_q <= pipe_step_t'(1);
            end else if (busy_o) begin
                step_q <= step_q + 1'b1;
                // drain done once the selector has pulsed
                if (step_q == pipe_step_t'(PIPE_LATENCY)) begin
                    busy_o <= 1'b0;
                end
            end
        end
    end

    // clause copy and issued literal
    always_ff @(posedge clk) begin
        if (start_i) begin
            clause_q <= clause_i;
        end
        if (issue_now) begin
            iss_lit_o   <= next_lit;
            iss_index_o <= start_i ? '0 : lit_index_t'(step_q);
        end
    end

    // a new clause would clobber the one in flight
    no_start_while_busy: assert property (
        @(posedge clk) disable iff (rst_i) busy_o |-> !start_i
    );

endmodule

`default_nettype wire

// ==== rtl/flip_pkg.sv ====
////////////////////////////////////////
// flip pipeline bookkeeping
// index, count and step types and the
// fixed start-to-done latency
////////////////////////////////////////
`default_nettype none

package flip_pkg;

    // position of a literal inside the clause
    typedef logic [$clog2(sat_pkg::NSAT)-1:0] lit_index_t;

    // 0 up to MC breaking clauses
    typedef logic [$clog2(sat_pkg::MC+1)-1:0] break_count_t;

    // issue over NSAT cycles, then table read, evaluate and select
    localparam int PIPE_LATENCY = sat_pkg::NSAT + 3;

    // step counter runs up to PIPE_LATENCY inclusive
    typedef logic [$clog2(PIPE_LATENCY+1)-1:0] pipe_step_t;

    // one variable-table port per other literal of every slot
    localparam int READ_PORTS = sat_pkg::MC * sat_pkg::OTHER_LITS;

endpackage

`default_nettype wire

// ==== rtl/sat_pkg.sv ====
////////////////////////////////////////
// sat problem encoding
// clause, literal and variable shapes plus the
// layout of one occurrence-table row
////////////////////////////////////////
`default_nettype none

package sat_pkg;

    // literals per clause
    localparam int NSAT = 3;
    // size of the assignment
    localparam int NUM_VARIABLES = 64;
    // max clauses a single literal appears in
    localparam int MC = 8;
    // literals of an occurrence besides the looked-up one
    localparam int OTHER_LITS = NSAT - 1;

    localparam int VAR_W = $clog2(NUM_VARIABLES);
    // negation bit sits on top of the address
    localparam int LIT_W = VAR_W + 1;
    // slot select inside one occurrence row
    localparam int SLOT_W = $clog2(MC);

    typedef logic [VAR_W-1:0] var_addr_t;
    typedef logic [SLOT_W-1:0] occ_slot_t;

    // true when the variable value differs from neg
    typedef struct packed {
        logic      neg;
        var_addr_t addr;
    } lit_t;

    // one clause holding the looked-up literal, minus that literal
    typedef struct packed {
        logic                      valid;
        lit_t [OTHER_LITS-1:0]     lits;
    } occ_entry_t;

    typedef occ_entry_t [MC-1:0] occ_row_t;

    // literal 0 in the low bits
    typedef lit_t [NSAT-1:0] clause_t;

endpackage

`default_nettype wire
